// ==== src.f ====
hdl/l2_tag_pkg.sv
hdl/tag_ram.sv
hdl/tag_way.sv
hdl/tag_resolve.sv
hdl/tag_init.sv
hdl/l2_tag_top.sv
bench/l2_tag_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the L2 tag directory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/10ps \
  -f src.f --top-module l2_tag_tb -o l2_tag_sim

./obj_dir/l2_tag_sim | tee sim.log

if grep -q "^All tests passed$" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi

// ==== bench/l2_tag_tb.sv ====
// L2 tag directory testbench
`timescale 1ns/10ps
`default_nettype none

module l2_tag_tb;
  import l2_tag_pkg::*;

  localparam int num_directed = 80;
  localparam int num_random   = 400;
  localparam int run_cycles   = 16 + 256 + num_directed + 2 * num_random + 100;

  typedef struct packed {
    logic   rsp_valid;
    rsp_t   rsp;
    logic   evict_valid;
    evict_t evict;
  } result_t;

  typedef struct packed {
    logic [63:0] stamp;
    result_t     res;
  } expect_t;

  logic       clk;
  logic       rst;
  logic       cmd_valid;
  cmd_t       cmd;
  logic       ready;
  logic       rsp_valid;
  rsp_t       rsp;
  logic       evict_valid;
  evict_t     evict;

  tag_entry_t  mdl [num_ways][2][num_sets];
  logic [15:0] mdl_lfsr;
  expect_t     exp_q [$];
  expect_t     cur;
  result_t     last_res;
  logic        checking;
  int          seed;
  int          checks;
  int          value_errors;
  int          other_errors;

  l2_tag_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .ready       (ready),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .evict_valid (evict_valid),
    .evict       (evict)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [15:0] lfsr_next(logic [15:0] l);
    return {1'b0, l[15:1]} ^ (l[0] ? 16'hb400 : 16'h0000);
  endfunction

  function automatic line_addr_t make_line(int tag, int idx, logic bank);
    return {tag[22:0], idx[7:0], bank};
  endfunction

  function automatic logic line_present(line_addr_t line);
    logic found;
    found = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (mdl[w][line[0]][line[8:1]].valid && mdl[w][line[0]][line[8:1]].tag == line[31:9]) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Expected outputs of one command; the model state is updated on the way.
  function automatic result_t model_command(cmd_t c);
    result_t    r;
    line_addr_t bl [2];
    logic       used [2];
    logic       tgt;
    logic       hit;
    int         first_hit;
    int         victim;
    tag_entry_t old;
    r = '0;
    tgt = c.line[0];
    first_hit = -1;
    for (int b = 0; b < 2; b++) begin
      bl[b] = (tgt == b[0]) ? c.line : c.line + 32'd1;
      used[b] = (tgt == b[0]) || (c.split && (c.op == op_lookup || c.op == op_write));
    end
    if (c.op != op_fill) begin
      for (int b = 0; b < 2; b++) begin
        for (int w = 0; w < num_ways; w++) begin
          old = mdl[w][b][bl[b][8:1]];
          hit = used[b] && old.valid && (old.tag == bl[b][31:9]);
          if (hit) begin
            if (b == 0) begin
              r.rsp.hit_even = 1'b1;
            end else begin
              r.rsp.hit_odd = 1'b1;
            end
            if (tgt == b[0] && first_hit < 0) begin
              first_hit = w;
              r.rsp.excl = old.excl;
              r.rsp.dirty = old.dirty;
            end
            if (c.op == op_write) begin
              mdl[w][b][bl[b][8:1]].dirty = 1'b1;
            end else if (c.op == op_inval) begin
              mdl[w][b][bl[b][8:1]] = '0;
            end
          end
        end
      end
      r.rsp_valid = (c.op == op_lookup) || (c.op == op_write);
      if (c.op == op_inval && first_hit >= 0) begin
        r.evict_valid = 1'b1;
        r.evict.line = c.line;
        r.evict.dirty = r.rsp.dirty;
      end
    end else begin
      victim = -1;
      for (int w = 0; w < num_ways; w++) begin
        if (victim < 0 && !mdl[w][tgt][c.line[8:1]].valid) begin
          victim = w;
        end
      end
      if (victim < 0) begin
        victim = int'(mdl_lfsr[1:0]);
        mdl_lfsr = lfsr_next(mdl_lfsr);
      end
      old = mdl[victim][tgt][c.line[8:1]];
      if (old.valid) begin
        r.evict_valid = 1'b1;
        r.evict.line = {old.tag, c.line[8:0]};
        r.evict.dirty = old.dirty;
      end
      mdl[victim][tgt][c.line[8:1]] = '{tag: c.line[31:9], valid: 1'b1, excl: c.excl, dirty: 1'b0};
    end
    return r;
  endfunction

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  // Called at a falling edge; returns at the next one.
  task automatic issue(input cmd_op_e op, input line_addr_t line, input logic split,
                       input logic excl);
    cmd_t    c;
    expect_t e;
    c.op = op;
    c.line = line;
    c.split = split;
    c.excl = excl;
    last_res = '0;
    if (ready) begin
      last_res = model_command(c);
      e.stamp = $time;
      e.res = last_res;
      exp_q.push_back(e);
    end
    cmd = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      value_errors++;
      $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  always @(negedge clk) begin
    if (checking) begin
      if (exp_q.size() > 0 && exp_q[0].stamp < $time) begin
        cur = exp_q.pop_front();
        check_value("rsp_valid", 32'(cur.res.rsp_valid), 32'(rsp_valid));
        if (cur.res.rsp_valid) begin
          check_value("rsp.hit_even", 32'(cur.res.rsp.hit_even), 32'(rsp.hit_even));
          check_value("rsp.hit_odd", 32'(cur.res.rsp.hit_odd), 32'(rsp.hit_odd));
          check_value("rsp.excl", 32'(cur.res.rsp.excl), 32'(rsp.excl));
          check_value("rsp.dirty", 32'(cur.res.rsp.dirty), 32'(rsp.dirty));
        end
        check_value("evict_valid", 32'(cur.res.evict_valid), 32'(evict_valid));
        if (cur.res.evict_valid) begin
          check_value("evict.line", cur.res.evict.line, evict.line);
          check_value("evict.dirty", 32'(cur.res.evict.dirty), 32'(evict.dirty));
        end
      end else begin
        check_value("rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("evict_valid", 32'd0, 32'(evict_valid));
      end
    end
  end

  initial begin
    #(run_cycles * 10);
    $display("Timeout: the run did not finish within %0d cycles", run_cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int          n;
    logic [31:0] rnd;
    line_addr_t  ln;
    clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    checking = 1'b0;
    seed = 32'h4ad5e141;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    mdl_lfsr = lfsr_seed;
    for (int w = 0; w < num_ways; w++) begin
      for (int b = 0; b < 2; b++) begin
        for (int s = 0; s < num_sets; s++) begin
          mdl[w][b][s] = '0;
        end
      end
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    checking = 1'b1;

    // Init sweep; fills sent every cycle while ready is low must be dropped.
    n = 0;
    while (!ready && n < 300) begin
      issue(op_fill, make_line(3, 8'h40, 1'b0), 1'b0, 1'b1);
      n++;
    end
    check_value("ready cycles", 32'd256, 32'(n));
    issue(op_lookup, make_line(3, 8'h40, 1'b0), 1'b0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      issue(op_lookup, $random(seed), i[0], 1'b0);
    end

    // Fills into free ways, then hits.
    for (int t = 1; t <= 4; t++) begin
      issue(op_fill, make_line(t, 8'h40, 1'b0), 1'b0, t[0]);
    end
    for (int t = 1; t <= 4; t++) begin
      issue(op_lookup, make_line(t, 8'h40, 1'b0), 1'b0, 1'b0);
    end

    // Dirty marking, and split accesses from an odd line into the next even line.
    issue(op_write, make_line(2, 8'h40, 1'b0), 1'b0, 1'b0);
    issue(op_lookup, make_line(2, 8'h40, 1'b0), 1'b0, 1'b0);
    issue(op_fill, make_line(5, 8'h10, 1'b1), 1'b0, 1'b1);
    issue(op_fill, make_line(5, 8'h11, 1'b0), 1'b0, 1'b0);
    issue(op_lookup, make_line(5, 8'h10, 1'b1), 1'b1, 1'b0);
    issue(op_write, make_line(5, 8'h10, 1'b1), 1'b1, 1'b0);
    issue(op_lookup, make_line(5, 8'h10, 1'b1), 1'b1, 1'b0);
    issue(op_lookup, make_line(5, 8'h11, 1'b0), 1'b0, 1'b0);
    issue(op_lookup, make_line(5, 8'h11, 1'b0), 1'b1, 1'b0);

    // Fills into a full set evict by the LFSR; the victim then misses.
    for (int t = 1; t <= 4; t++) begin
      issue(op_write, make_line(t, 8'h40, 1'b0), 1'b0, 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      issue(op_fill, make_line(10 + k, 8'h40, 1'b0), 1'b0, k[0]);
      if (last_res.evict_valid) begin
        issue(op_lookup, last_res.evict.line, 1'b0, 1'b0);
      end
    end

    // Invalidate present and absent lines.
    issue(op_inval, make_line(5, 8'h10, 1'b1), 1'b0, 1'b0);
    issue(op_lookup, make_line(5, 8'h10, 1'b1), 1'b0, 1'b0);
    issue(op_inval, make_line(99, 8'h40, 1'b0), 1'b0, 1'b0);

    // Back-to-back commands on one set.
    ln = make_line(7, 8'h60, 1'b1);
    issue(op_fill, ln, 1'b0, 1'b1);
    issue(op_write, ln, 1'b0, 1'b0);
    issue(op_lookup, ln, 1'b0, 1'b0);
    issue(op_inval, ln, 1'b0, 1'b0);
    issue(op_lookup, ln, 1'b0, 1'b0);
    issue(op_fill, ln, 1'b0, 1'b0);
    issue(op_fill, make_line(8, 8'h60, 1'b1), 1'b0, 1'b1);
    issue(op_lookup, make_line(8, 8'h60, 1'b1), 1'b0, 1'b0);

    // Random traffic over a few tags and sets, wrapping at index 255.
    for (int i = 0; i < num_random; i++) begin
      rnd = $random(seed);
      ln = make_line(8 + int'(rnd[4:2]), 254 + int'(rnd[6:5]), rnd[7]);
      if (cmd_op_e'(rnd[1:0]) == op_fill && line_present(ln)) begin
        issue(op_lookup, ln, rnd[8], rnd[9]);
      end else begin
        issue(cmd_op_e'(rnd[1:0]), ln, rnd[8], rnd[9]);
      end
      if (rnd[12:10] == 3'd0) begin
        @(negedge clk);
      end
    end

    repeat (3) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("Expected results never arrived for %0d commands", exp_q.size());
    end
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/l2_tag_top.sv ====
// L2 tag directory top level
`timescale 1ns/10ps
`default_nettype none

module l2_tag_top (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                cmd_valid,
  input  wire l2_tag_pkg::cmd_t    cmd,
  output logic                     ready,
  output logic                     rsp_valid,
  output l2_tag_pkg::rsp_t         rsp,
  output logic                     evict_valid,
  output l2_tag_pkg::evict_t       evict
);
  import l2_tag_pkg::*;

  logic                cmd_acc;
  logic                clr_en;
  logic [set_bits-1:0] clr_index;
  logic [num_ways-1:0] fill_sel;
  way_probe_t          probes [num_ways];

  // Strobes while the sweep runs are dropped.
  assign cmd_acc = cmd_valid && ready;

  tag_init init_i (
    .clk       (clk),
    .rst       (rst),
    .clr_en    (clr_en),
    .clr_index (clr_index),
    .ready     (ready)
  );

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    tag_way way_i (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_acc),
      .cmd       (cmd),
      .fill_sel  (fill_sel[w]),
      .clr_en    (clr_en),
      .clr_index (clr_index),
      .probe     (probes[w])
    );
  end

  tag_resolve resolve_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_acc),
    .cmd         (cmd),
    .probes      (probes),
    .fill_sel    (fill_sel),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .evict_valid (evict_valid),
    .evict       (evict)
  );

endmodule

`default_nettype wire

// ==== hdl/tag_init.sv ====
// Post-reset tag clear sweep
`timescale 1ns/10ps
`default_nettype none

module tag_init (
  input  wire logic                            clk,
  input  wire logic                            rst,
  output logic                                 clr_en,
  output logic [l2_tag_pkg::set_bits-1:0]      clr_index,
  output logic                                 ready
);
  import l2_tag_pkg::*;

  logic [set_bits-1:0] count;
  logic                done;

  // One pass over every index, then stay idle until the next reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      done  <= 1'b0;
    end else if (!done) begin
      count <= count + 1'b1;
      if (count == set_bits'(num_sets - 1)) begin
        done <= 1'b1;
      end
    end
  end

  assign clr_en    = !done;
  assign clr_index = count;
  assign ready     = done;

endmodule

`default_nettype wire

// ==== hdl/tag_resolve.sv ====
// Way merge, victim choice and evict report
`timescale 1ns/10ps
`default_nettype none

module tag_resolve (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              cmd_valid,
  input  wire l2_tag_pkg::cmd_t                  cmd,
  input  wire l2_tag_pkg::way_probe_t            probes [l2_tag_pkg::num_ways],
  output logic [l2_tag_pkg::num_ways-1:0]        fill_sel,
  output logic                                   rsp_valid,
  output l2_tag_pkg::rsp_t                       rsp,
  output logic                                   evict_valid,
  output l2_tag_pkg::evict_t                     evict
);
  import l2_tag_pkg::*;

  logic                s1_valid;
  cmd_op_e             s1_op;
  line_addr_t          s1_line;
  logic [lfsr_bits-1:0] lfsr;
  logic [num_ways-1:0] tgt_hit;
  logic [way_bits-1:0] hit_way;
  logic [way_bits-1:0] victim;
  logic [way_bits-1:0] sel_way;
  logic                any_free;
  logic                is_fill;
  logic                is_inval;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      s1_op   <= cmd.op;
      s1_line <= cmd.line;
    end
  end

  assign is_fill  = s1_valid && (s1_op == op_fill);
  assign is_inval = s1_valid && (s1_op == op_inval);

  // Scan from the top so the lowest way wins.
  always_comb begin
    victim   = lfsr[way_bits-1:0];
    any_free = 1'b0;
    hit_way  = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      tgt_hit[w] = s1_line[0] ? probes[w].hit_odd : probes[w].hit_even;
      if (!probes[w].valid_tgt) begin
        victim   = way_bits'(w);
        any_free = 1'b1;
      end
      if (tgt_hit[w]) begin
        hit_way = way_bits'(w);
      end
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  assign rsp_valid = s1_valid && ((s1_op == op_lookup) || (s1_op == op_write));

  always_comb begin
    rsp.hit_even = 1'b0;
    rsp.hit_odd  = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      rsp.hit_even = rsp.hit_even | probes[w].hit_even;
      rsp.hit_odd  = rsp.hit_odd | probes[w].hit_odd;
    end
    rsp.excl  = (|tgt_hit) & probes[hit_way].excl;
    rsp.dirty = (|tgt_hit) & probes[hit_way].dirty;
  end

  //////////////////////////////
  // Fill victim and evict
  //////////////////////////////

  assign fill_sel = is_fill ? (num_ways'(1) << victim) : '0;
  assign sel_way  = is_fill ? victim : hit_way;

  assign evict_valid = (is_fill && probes[victim].valid_tgt) || (is_inval && (|tgt_hit));
  assign evict.line  = {probes[sel_way].victim_tag, s1_line[set_bits:0]};
  assign evict.dirty = probes[sel_way].dirty;

  // Steps only when a fill finds the set full.
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= lfsr_seed;
    end else if (is_fill && !any_free) begin
      lfsr <= {1'b0, lfsr[lfsr_bits-1:1]} ^ (lfsr[0] ? lfsr_taps : '0);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tag_way.sv ====
// One tag directory way
`timescale 1ns/10ps
`default_nettype none

module tag_way (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              cmd_valid,
  input  wire l2_tag_pkg::cmd_t                  cmd,
  input  wire logic                              fill_sel,
  input  wire logic                              clr_en,
  input  wire logic [l2_tag_pkg::set_bits-1:0]   clr_index,
  output l2_tag_pkg::way_probe_t                 probe
);
  import l2_tag_pkg::*;

  logic       s1_valid;
  cmd_t       s1_cmd;
  logic       s1_tgt;
  logic       s1_access;
  line_addr_t rd_line [2];
  line_addr_t s1_line [2];
  tag_entry_t rd_entry [2];
  tag_entry_t tgt_entry;
  logic [1:0] bank_used;
  logic [1:0] hit;

  //////////////////////////////
  // Stage 1 command register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      s1_cmd <= cmd;
    end
  end

  assign s1_tgt    = s1_cmd.line[0];
  assign s1_access = (s1_cmd.op == op_lookup) || (s1_cmd.op == op_write);

  //////////////////////////////
  // Even and odd banks
  //////////////////////////////

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic       we;
    tag_entry_t wdata;

    assign rd_line[b] = bank_line(cmd.line, 1'(b));
    assign s1_line[b] = bank_line(s1_cmd.line, 1'(b));

    // Other bank only counts for a split lookup or write.
    assign bank_used[b] = s1_valid &&
                          ((s1_tgt == 1'(b)) || (s1_cmd.split && s1_access));
    assign hit[b] = bank_used[b] && rd_entry[b].valid &&
                    (rd_entry[b].tag == line_tag(s1_line[b]));

    always_comb begin
      we    = 1'b0;
      wdata = rd_entry[b];
      if (clr_en) begin
        we    = 1'b1;
        wdata = '0;
      end else if (s1_valid) begin
        case (s1_cmd.op)
          op_write: begin
            if (hit[b]) begin
              we          = 1'b1;
              wdata.dirty = 1'b1;
            end
          end
          op_inval: begin
            if (hit[b]) begin
              we    = 1'b1;
              wdata = '0;
            end
          end
          op_fill: begin
            if (fill_sel && (s1_tgt == 1'(b))) begin
              we          = 1'b1;
              wdata.tag   = line_tag(s1_line[b]);
              wdata.valid = 1'b1;
              wdata.excl  = s1_cmd.excl;
              wdata.dirty = 1'b0;
            end
          end
          default: begin
            we = 1'b0;
          end
        endcase
      end
    end

    tag_ram ram_i (
      .clk      (clk),
      .rst      (rst),
      .rd_en    (cmd_valid),
      .rd_index (line_index(rd_line[b])),
      .rd_data  (rd_entry[b]),
      .wr_en    (we),
      .wr_index (clr_en ? clr_index : line_index(s1_line[b])),
      .wr_data  (wdata)
    );
  end

  //////////////////////////////
  // Probe to the resolver
  //////////////////////////////

  assign tgt_entry = rd_entry[s1_tgt];

  always_comb begin
    probe.hit_even   = hit[0];
    probe.hit_odd    = hit[1];
    probe.valid_tgt  = tgt_entry.valid;
    probe.excl       = tgt_entry.excl;
    probe.dirty      = tgt_entry.dirty;
    probe.victim_tag = tgt_entry.tag;
  end

endmodule

`default_nettype wire

// ==== hdl/tag_ram.sv ====
// Tag bank RAM
`timescale 1ns/10ps
`default_nettype none

module tag_ram (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              rd_en,
  input  wire logic [l2_tag_pkg::set_bits-1:0]   rd_index,
  output l2_tag_pkg::tag_entry_t                 rd_data,
  input  wire logic                              wr_en,
  input  wire logic [l2_tag_pkg::set_bits-1:0]   wr_index,
  input  wire l2_tag_pkg::tag_entry_t            wr_data
);
  import l2_tag_pkg::*;

  tag_entry_t          ram [num_sets];
  logic [set_bits-1:0] rd_index_q;

  // Read goes through the registered index, so a write is seen next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      ram[wr_index] <= wr_data;
    end
  end

  assign rd_data = ram[rd_index_q];

endmodule

`default_nettype wire

// ==== hdl/l2_tag_pkg.sv ====
// L2 tag directory definitions
`default_nettype none

package l2_tag_pkg;

  localparam int num_ways  = 4;
  localparam int way_bits  = $clog2(num_ways);
  localparam int set_bits  = 8;
  localparam int num_sets  = 1 << set_bits;
  localparam int line_bits = 32;
  // Line bit 0 picks the bank, the next set_bits bits index it.
  localparam int tag_bits  = line_bits - set_bits - 1;

  localparam int          lfsr_bits = 16;
  localparam logic [15:0] lfsr_seed = 16'hf0fe;
  // Taps 16, 14, 13 and 11, right-shifting Galois form.
  localparam logic [15:0] lfsr_taps = 16'hb400;

  typedef logic [line_bits-1:0] line_addr_t;

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic                valid;
    logic                excl;
    logic                dirty;
  } tag_entry_t;

  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_write  = 2'd1,
    op_fill   = 2'd2,
    op_inval  = 2'd3
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e    op;
    line_addr_t line;
    logic       split;
    logic       excl;
  } cmd_t;

  typedef struct packed {
    logic                hit_even;
    logic                hit_odd;
    logic                valid_tgt;
    logic                excl;
    logic                dirty;
    logic [tag_bits-1:0] victim_tag;
  } way_probe_t;

  typedef struct packed {
    logic hit_even;
    logic hit_odd;
    logic excl;
    logic dirty;
  } rsp_t;

  typedef struct packed {
    line_addr_t line;
    logic       dirty;
  } evict_t;

  function automatic logic [tag_bits-1:0] line_tag(line_addr_t line);
    return line[line_bits-1:set_bits+1];
  endfunction

  function automatic logic [set_bits-1:0] line_index(line_addr_t line);
    return line[set_bits:1];
  endfunction

  // Line that lands in the given bank, either the line itself or the next one.
  function automatic line_addr_t bank_line(line_addr_t line, logic odd);
    return (line[0] == odd) ? line : line + 1'b1;
  endfunction

endpackage

`default_nettype wire
